// File: filelist.f
hw/rom_hash_pkg.sv
hw/rom_check_pkg.sv
hw/rom_check_counter.sv
hw/rom_hash.sv
hw/rom_digest_regs.sv
hw/rom_check_compare.sv
hw/rom_check_fsm.sv
hw/rom_check_top.sv
tb/rom_check_assertions.sv
tb/rom_check_monitor.sv
tb/tb_rom_check.sv

// File: Makefile
SIM      := verilator
TOP      := tb_rom_check
FILELIST := filelist.f
FLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP)
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^sim passed$$" $(LOG) || (echo "Simulation did not pass" && exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// File: tb/tb_rom_check.sv
`timescale 1ns/1ps

module tb_rom_check;

  localparam int RomDepth = 64;
  localparam int TopCount = 8;
  localparam int W = rom_hash_pkg::WordW;
  localparam int NumImages = 4;
  // Each image runs clean, with random busy, and with a corrupted top region
  localparam int NumTests = 3 * NumImages;
  localparam int unsigned CycleLimit = NumTests * (4 * RomDepth + 4 * TopCount + 50);

  logic                          clk_i;
  logic                          rst_ni;
  logic [W-1:0]                  rom_data_i;
  logic                          hash_busy_i;
  logic [$clog2(RomDepth)-1:0]   rom_addr_o;
  logic                          rom_req_o;
  rom_check_pkg::check_status_t  status_o;
  rom_check_pkg::key_data_t      key_o;
  logic                          bus_select_o;
  logic                          alert_o;

  logic [RomDepth-1:0][W-1:0]    rom_mem;
  logic [TopCount-1:0][W-1:0]    model_digest;
  logic                          busy_mode;
  int unsigned                   cycle_cnt = 0;
  int unsigned                   pass_cnt;
  int unsigned                   fail_cnt;
  int unsigned                   err_cnt;

  always #4 clk_i = ~clk_i;

  rom_check_top #(
    .RomDepth (RomDepth),
    .TopCount (TopCount)
  ) i_rom_check_top (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rom_data_i   (rom_data_i),
    .hash_busy_i  (hash_busy_i),
    .rom_addr_o   (rom_addr_o),
    .rom_req_o    (rom_req_o),
    .status_o     (status_o),
    .key_o        (key_o),
    .bus_select_o (bus_select_o),
    .alert_o      (alert_o)
  );

  rom_check_monitor #(
    .RomDepth (RomDepth),
    .TopCount (TopCount)
  ) i_monitor (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .rom_i          (rom_mem),
    .rom_addr_i     (rom_addr_o),
    .rom_req_i      (rom_req_o),
    .status_i       (status_o),
    .key_i          (key_o),
    .bus_select_i   (bus_select_o),
    .alert_i        (alert_o),
    .model_digest_o (model_digest),
    .pass_cnt_o     (pass_cnt),
    .fail_cnt_o     (fail_cnt),
    .err_cnt_o      (err_cnt)
  );

  // ROM answers one cycle after a request and holds the word otherwise
  always @(posedge clk_i) begin
    if (rom_req_o) begin
      rom_data_i <= rom_mem[rom_addr_o];
    end
  end

  // About half the cycles are busy when enabled
  always @(posedge clk_i) begin
    if (busy_mode) begin
      hash_busy_i <= 1'($urandom % 2);
    end else begin
      hash_busy_i <= 1'b0;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CycleLimit) begin
      $display("ERROR: run timed out after %0d cycles before all tests finished", cycle_cnt);
      $display("sim failed");
      $finish;
    end
  end

  task automatic load_image();
    for (int i = 0; i < RomDepth - TopCount; i++) begin
      rom_mem[i] <= $urandom;
    end
    @(posedge clk_i);
  endtask

  task automatic run_test(input logic use_busy, input logic corrupt);
    int           flip_word;
    logic [W-1:0] flip_mask;
    logic [W-1:0] word;
    flip_word = int'($urandom_range(TopCount - 1));
    flip_mask = W'(1) << ($urandom % W);
    rst_ni    <= 1'b0;
    busy_mode <= use_busy;
    repeat (3) @(posedge clk_i);
    // The monitor has latched the model digest of the low region by now
    for (int i = 0; i < TopCount; i++) begin
      word = model_digest[i];
      if (corrupt && i == flip_word) begin
        word = word ^ flip_mask;
      end
      rom_mem[RomDepth - TopCount + i] <= word;
    end
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    do begin
      @(negedge clk_i);
    end while (!status_o.done);
    // A few cycles in Done let the monitor see the outputs settle
    repeat (4) @(posedge clk_i);
    busy_mode <= 1'b0;
    @(posedge clk_i);
  endtask

  initial begin
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    rom_data_i  = '0;
    hash_busy_i = 1'b0;
    busy_mode   = 1'b0;
    rom_mem     = '0;
    void'($urandom(94795));
    for (int img = 0; img < NumImages; img++) begin
      load_image();
      run_test(1'b0, 1'b0);
      run_test(1'b1, 1'b0);
      run_test(1'b0, 1'b1);
    end
    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             NumTests, pass_cnt, fail_cnt, err_cnt);
    if (pass_cnt == NumTests && fail_cnt == 0 && err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: tb/rom_check_monitor.sv
`timescale 1ns/1ps

module rom_check_monitor #(
  parameter int RomDepth = 64,
  parameter int TopCount = 8
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic [RomDepth-1:0][rom_hash_pkg::WordW-1:0]  rom_i,
  input  logic [$clog2(RomDepth)-1:0]                   rom_addr_i,
  input  logic                                          rom_req_i,
  input  rom_check_pkg::check_status_t                  status_i,
  input  rom_check_pkg::key_data_t                      key_i,
  input  logic                                          bus_select_i,
  input  logic                                          alert_i,
  output logic [TopCount-1:0][rom_hash_pkg::WordW-1:0]  model_digest_o,
  output int unsigned                                   pass_cnt_o,
  output int unsigned                                   fail_cnt_o,
  output int unsigned                                   err_cnt_o
);

  localparam int W = rom_hash_pkg::WordW;
  localparam int LowCount = RomDepth - TopCount;

  logic [TopCount-1:0][W-1:0] model_q;
  int unsigned                req_cnt [RomDepth];
  int unsigned                test_idx = 0;
  int unsigned                test_err = 0;
  int unsigned                pass_cnt = 0;
  int unsigned                fail_cnt = 0;
  int unsigned                err_cnt = 0;
  logic                       done_seen = 1'b0;

  // Reference digest of the low region from absorbing each low word and TopCount finalize rounds
  function automatic logic [TopCount-1:0][W-1:0] hash_image(
    input logic [RomDepth-1:0][W-1:0] img
  );
    logic [TopCount-1:0][W-1:0] h;
    logic [W-1:0]               x;
    for (int j = 0; j < TopCount; j++) begin
      h[j] = rom_hash_pkg::IvWords[j];
    end
    // Word k lands in chaining word k mod TopCount
    for (int k = 0; k < LowCount; k++) begin
      x = h[k % TopCount] ^ img[k];
      h[k % TopCount] = ((x << rom_hash_pkg::RotAmt) | (x >> (W - rom_hash_pkg::RotAmt)))
                        + W'(k);
    end
    // Each round walks j upward, so the last add already sees the new word 0
    for (int r = 0; r < TopCount; r++) begin
      for (int j = 0; j < TopCount; j++) begin
        h[j] = h[j] + h[(j + 1) % TopCount];
      end
    end
    return h;
  endfunction

  task automatic report(input string msg);
    err_cnt++;
    test_err++;
    $display("%s", msg);
  endtask

  // Final comparison once done rises, then one summary line for the test
  task automatic check_result();
    logic exp_good;
    exp_good = 1'b1;
    for (int i = 0; i < TopCount; i++) begin
      if (rom_i[LowCount + i] != model_q[i]) begin
        exp_good = 1'b0;
      end
    end
    if (status_i.good !== exp_good) begin
      report($sformatf("MISMATCH at %0t: test %0d good is %0b, expected %0b",
                       $time, test_idx + 1, status_i.good, exp_good));
    end
    if (key_i.data !== model_q) begin
      report($sformatf("MISMATCH at %0t: test %0d key data %h, expected %h",
                       $time, test_idx + 1, key_i.data, model_q));
    end
    // The sweep must touch every ROM word exactly once
    for (int a = 0; a < RomDepth; a++) begin
      if (req_cnt[a] != 1) begin
        report($sformatf("ERROR at %0t: test %0d read address %0d %0d times instead of once",
                         $time, test_idx + 1, a, req_cnt[a]));
      end
    end
    test_idx++;
    if (test_err == 0) begin
      pass_cnt++;
      $display("test %0d: PASS, good %0b", test_idx, status_i.good);
    end else begin
      fail_cnt++;
      $display("test %0d: FAIL with %0d errors", test_idx, test_err);
    end
  endtask

  // Outputs are sampled on the falling edge, half a cycle after the inputs change
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      // The low region is stable while reset is held
      model_q = hash_image(rom_i);
      for (int a = 0; a < RomDepth; a++) begin
        req_cnt[a] = 0;
      end
      test_err  = 0;
      done_seen = 1'b0;
    end else begin
      if (alert_i) begin
        report($sformatf("ERROR at %0t: alert raised during test %0d", $time, test_idx + 1));
      end
      if (key_i.valid !== status_i.done) begin
        report($sformatf("MISMATCH at %0t: key valid %0b, done %0b",
                         $time, key_i.valid, status_i.done));
      end
      if (bus_select_i !== status_i.done) begin
        report($sformatf("MISMATCH at %0t: bus select %0b, done %0b",
                         $time, bus_select_i, status_i.done));
      end
      if (status_i.done && rom_req_i) begin
        report($sformatf("ERROR at %0t: ROM read requested after done", $time));
      end
      // Done is held until the next reset
      if (done_seen && !status_i.done) begin
        report($sformatf("ERROR at %0t: done dropped before reset in test %0d",
                         $time, test_idx));
      end
      if (rom_req_i) begin
        if (int'(rom_addr_i) >= RomDepth) begin
          report($sformatf("ERROR at %0t: read address %0d is past the ROM", $time, rom_addr_i));
        end else begin
          req_cnt[rom_addr_i]++;
        end
      end
      if (status_i.done && !done_seen) begin
        done_seen = 1'b1;
        check_result();
      end
    end
  end

  assign model_digest_o = model_q;
  assign pass_cnt_o     = pass_cnt;
  assign fail_cnt_o     = fail_cnt;
  assign err_cnt_o      = err_cnt;

endmodule

// File: tb/rom_check_assertions.sv
`timescale 1ns/1ps

module rom_check_assertions (
  input logic                      clk_i,
  input logic                      rst_ni,
  input rom_check_pkg::fsm_state_e state_i,
  input logic                      hash_absorb_i,
  input logic                      hash_last_i,
  input logic                      bus_select_i
);

  // States are numbered in visiting order, so a legal step never lowers the value
  state_forward: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_i >= $past(state_i))
    else $error("checker FSM stepped back to an earlier state");

  // The last low word is only flagged while it is offered to the hash
  last_with_absorb: assert property (@(posedge clk_i) disable iff (!rst_ni)
    hash_last_i |-> hash_absorb_i)
    else $error("hash last flag raised without an absorb strobe");

  // The bus regains the ROM only after a finished check
  bus_only_in_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_select_i |-> (state_i == rom_check_pkg::Done))
    else $error("bus select high outside the Done state");

endmodule

bind rom_check_fsm rom_check_assertions i_fsm_assertions (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .state_i       (state_q),
  .hash_absorb_i (hash_absorb_o),
  .hash_last_i   (hash_last_o),
  .bus_select_i  (bus_select_o)
);

// File: hw/rom_check_top.sv
`timescale 1ns/1ps

module rom_check_top #(
  parameter int RomDepth = 64,
  parameter int TopCount = 8
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic [rom_hash_pkg::WordW-1:0] rom_data_i,
  input  logic                           hash_busy_i,
  output logic [$clog2(RomDepth)-1:0]    rom_addr_o,
  output logic                           rom_req_o,
  output rom_check_pkg::check_status_t   status_o,
  output rom_check_pkg::key_data_t       key_o,
  output logic                           bus_select_o,
  output logic                           alert_o
);

  // The key block holds exactly KeyWords digest words and the low region must not be empty
  if (TopCount != rom_check_pkg::KeyWords || RomDepth <= TopCount + 1) begin : g_param_check
    $error("TopCount must equal KeyWords and RomDepth must exceed TopCount plus one");
  end

  logic                                          hash_ready;
  logic                                          hash_done;
  logic                                          hash_absorb;
  logic                                          hash_last;
  logic [TopCount-1:0][rom_hash_pkg::WordW-1:0]  hash_digest;
  logic [TopCount-1:0][rom_hash_pkg::WordW-1:0]  digest;
  logic [TopCount-1:0][rom_hash_pkg::WordW-1:0]  exp_digest;
  logic                                          exp_vld;
  logic [$clog2(TopCount)-1:0]                   exp_idx;

  rom_check_fsm #(
    .RomDepth (RomDepth),
    .TopCount (TopCount)
  ) u_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .hash_busy_i   (hash_busy_i),
    .hash_ready_i  (hash_ready),
    .hash_done_i   (hash_done),
    .digest_i      (digest),
    .exp_digest_i  (exp_digest),
    .hash_absorb_o (hash_absorb),
    .hash_last_o   (hash_last),
    .rom_addr_o    (rom_addr_o),
    .rom_req_o     (rom_req_o),
    .exp_vld_o     (exp_vld),
    .exp_idx_o     (exp_idx),
    .status_o      (status_o),
    .key_o         (key_o),
    .bus_select_o  (bus_select_o),
    .alert_o       (alert_o)
  );

  rom_hash #(
    .TopCount (TopCount)
  ) u_hash (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .busy_i   (hash_busy_i),
    .absorb_i (hash_absorb),
    .word_i   (rom_data_i),
    .last_i   (hash_last),
    .ready_o  (hash_ready),
    .done_o   (hash_done),
    .digest_o (hash_digest)
  );

  // Expected words come straight off the ROM data bus
  rom_digest_regs #(
    .TopCount (TopCount)
  ) u_digest_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .digest_vld_i (hash_done),
    .digest_i     (hash_digest),
    .exp_vld_i    (exp_vld),
    .exp_idx_i    (exp_idx),
    .exp_word_i   (rom_data_i),
    .digest_o     (digest),
    .exp_digest_o (exp_digest)
  );

endmodule

// File: hw/rom_check_fsm.sv
`timescale 1ns/1ps

module rom_check_fsm #(
  parameter int RomDepth = 64,
  parameter int TopCount = 8
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                                          hash_busy_i,
  input  logic                                          hash_ready_i,
  input  logic                                          hash_done_i,
  input  logic [TopCount-1:0][rom_hash_pkg::WordW-1:0]  digest_i,
  input  logic [TopCount-1:0][rom_hash_pkg::WordW-1:0]  exp_digest_i,
  output logic                                          hash_absorb_o,
  output logic                                          hash_last_o,
  output logic [$clog2(RomDepth)-1:0]                   rom_addr_o,
  output logic                                          rom_req_o,
  output logic                                          exp_vld_o,
  output logic [$clog2(TopCount)-1:0]                   exp_idx_o,
  output rom_check_pkg::check_status_t                  status_o,
  output rom_check_pkg::key_data_t                      key_o,
  output logic                                          bus_select_o,
  output logic                                          alert_o
);

  localparam int AW = $clog2(RomDepth);
  localparam int TAW = $clog2(TopCount);
  localparam logic [AW-1:0] TopStartAddr = AW'(RomDepth - TopCount);

  rom_check_pkg::fsm_state_e state_d;
  rom_check_pkg::fsm_state_e state_q;

  logic          counter_done;
  logic [AW-1:0] counter_read_addr;
  logic          counter_read_req;
  logic [AW-1:0] counter_data_addr;
  logic          counter_data_rdy;
  logic          counter_lnt;
  logic          start_checker_q;
  logic          checker_done;
  logic          checker_good;
  logic          checker_alert;
  logic          data_vld_q;
  logic          in_low;
  logic          in_top;
  logic          in_done;
  logic          done_q;
  logic          fsm_alert;
  logic          ready_mismatch;
  logic          unexpected_counter_change;
  logic [AW-1:0] rel_addr;

  rom_check_counter #(
    .RomDepth (RomDepth),
    .TopCount (TopCount)
  ) u_counter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .data_rdy_i  (counter_data_rdy),
    .read_addr_o (counter_read_addr),
    .read_req_o  (counter_read_req),
    .data_addr_o (counter_data_addr),
    .last_low_o  (counter_lnt),
    .done_o      (counter_done)
  );

  rom_check_compare #(
    .TopCount (TopCount)
  ) u_compare (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start_checker_q),
    .digest_i     (digest_i),
    .exp_digest_i (exp_digest_i),
    .done_o       (checker_done),
    .good_o       (checker_good),
    .alert_o      (checker_alert)
  );

  assign in_low  = (state_q == rom_check_pkg::ReadingLow);
  assign in_top  = (state_q == rom_check_pkg::ReadingHigh) ||
                   (state_q == rom_check_pkg::HashAhead);
  assign in_done = (state_q == rom_check_pkg::Done);

  // Any encoding outside the six working states, Invalid included, raises the alert
  assign fsm_alert = !(state_q inside {rom_check_pkg::ReadingLow, rom_check_pkg::ReadingHigh,
                                       rom_check_pkg::RomAhead, rom_check_pkg::HashAhead,
                                       rom_check_pkg::Checking, rom_check_pkg::Done});

  always_comb begin
    state_d = state_q;
    case (state_q)
      rom_check_pkg::ReadingLow: begin
        // Leave once the hash has taken the last low word
        if (counter_lnt && hash_absorb_o && hash_ready_i) begin
          state_d = rom_check_pkg::ReadingHigh;
        end
      end
      rom_check_pkg::ReadingHigh: begin
        case ({hash_done_i, counter_done})
          2'b01:   state_d = rom_check_pkg::RomAhead;
          2'b10:   state_d = rom_check_pkg::HashAhead;
          2'b11:   state_d = rom_check_pkg::Checking;
          default: state_d = rom_check_pkg::ReadingHigh;
        endcase
      end
      rom_check_pkg::RomAhead: begin
        if (hash_done_i) begin
          state_d = rom_check_pkg::Checking;
        end
      end
      rom_check_pkg::HashAhead: begin
        if (counter_done) begin
          state_d = rom_check_pkg::Checking;
        end
      end
      rom_check_pkg::Checking: begin
        if (checker_done) begin
          state_d = rom_check_pkg::Done;
        end
      end
      rom_check_pkg::Done: begin
        state_d = rom_check_pkg::Done;
      end
      default: begin
        state_d = rom_check_pkg::Invalid;
      end
    endcase

    // Done signals showing up in the wrong state mean the flow was disturbed
    if ((counter_done && in_low) ||
        (hash_done_i && !(state_q inside {rom_check_pkg::ReadingHigh,
                                          rom_check_pkg::RomAhead})) ||
        (checker_done && !(state_q inside {rom_check_pkg::Checking, rom_check_pkg::Done}))) begin
      state_d = rom_check_pkg::Invalid;
    end

    // Every alert also locks the FSM in Invalid
    if (alert_o) begin
      state_d = rom_check_pkg::Invalid;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= rom_check_pkg::ReadingLow;
    end else begin
      state_q <= state_d;
    end
  end

  // Mirrors the counter's data valid, set by a request and cleared when consumed
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_vld_q <= 1'b0;
    end else if (counter_read_req) begin
      data_vld_q <= 1'b1;
    end else if (counter_data_rdy) begin
      data_vld_q <= 1'b0;
    end
  end

  // Low words wait for the hash while top words are taken straight away
  assign counter_data_rdy = (in_low && hash_ready_i) || in_top;
  assign hash_absorb_o    = data_vld_q && in_low;
  assign hash_last_o      = counter_lnt;

  // Top words are stored by their offset from the start of the top region
  assign rel_addr  = counter_data_addr - TopStartAddr;
  assign exp_vld_o = data_vld_q && in_top;
  assign exp_idx_o = rel_addr[TAW-1:0];

  // Pulse the compare start on entry to Checking
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_checker_q <= 1'b0;
    end else begin
      start_checker_q <= (state_q != rom_check_pkg::Checking) &&
                         (state_d == rom_check_pkg::Checking);
    end
  end

  // The done flag follows the Done state one cycle later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
    end else begin
      done_q <= in_done;
    end
  end

  // In Done a counter that is no longer finished means the address was tampered with
  assign unexpected_counter_change = in_done && !counter_done;
  // The hash ready must be the inverse of busy
  assign ready_mismatch = hash_ready_i && hash_busy_i;

  assign alert_o = fsm_alert | checker_alert | unexpected_counter_change | ready_mismatch;

  assign rom_addr_o   = counter_read_addr;
  assign rom_req_o    = counter_read_req;
  // The bus gets the ROM back only after a finished check
  assign bus_select_o = done_q;
  assign status_o     = '{done: done_q, good: done_q && checker_good};
  assign key_o        = '{valid: done_q, data: digest_i};

endmodule

// File: hw/rom_check_compare.sv
`timescale 1ns/1ps

module rom_check_compare #(
  parameter int TopCount = 8
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                                          start_i,
  input  logic [TopCount-1:0][rom_hash_pkg::WordW-1:0]  digest_i,
  input  logic [TopCount-1:0][rom_hash_pkg::WordW-1:0]  exp_digest_i,
  output logic                                          done_o,
  output logic                                          good_o,
  output logic                                          alert_o
);

  localparam int TAW = $clog2(TopCount);

  typedef enum logic [1:0] {
    CmpIdle,
    CmpRun,
    CmpDone
  } cmp_state_e;

  cmp_state_e     state_q;
  logic [TAW-1:0] idx_q;
  logic           match_q;
  logic           word_eq;

  // One word pair is compared per cycle
  assign word_eq = (digest_i[idx_q] == exp_digest_i[idx_q]);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= CmpIdle;
      idx_q   <= '0;
      match_q <= 1'b0;
    end else begin
      case (state_q)
        CmpIdle: begin
          if (start_i) begin
            state_q <= CmpRun;
            idx_q   <= '0;
            match_q <= 1'b1;
          end
        end
        CmpRun: begin
          // A single differing word clears the flag for good
          match_q <= match_q & word_eq;
          idx_q   <= idx_q + TAW'(1);
          if (idx_q == TAW'(TopCount - 1)) begin
            state_q <= CmpDone;
          end
        end
        default: begin
          // Terminal, result is held
          state_q <= CmpDone;
        end
      endcase
    end
  end

  assign done_o  = (state_q == CmpDone);
  assign good_o  = done_o && match_q;
  // The check may only be started once
  assign alert_o = start_i && (state_q != CmpIdle);

endmodule

// File: hw/rom_digest_regs.sv
`timescale 1ns/1ps

module rom_digest_regs #(
  parameter int TopCount = 8
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                                          digest_vld_i,
  input  logic [TopCount-1:0][rom_hash_pkg::WordW-1:0]  digest_i,
  input  logic                                          exp_vld_i,
  input  logic [$clog2(TopCount)-1:0]                   exp_idx_i,
  input  logic [rom_hash_pkg::WordW-1:0]                exp_word_i,
  output logic [TopCount-1:0][rom_hash_pkg::WordW-1:0]  digest_o,
  output logic [TopCount-1:0][rom_hash_pkg::WordW-1:0]  exp_digest_o
);

  logic [TopCount-1:0][rom_hash_pkg::WordW-1:0] digest_q;
  logic [TopCount-1:0][rom_hash_pkg::WordW-1:0] exp_q;

  // Computed digest is taken whole on the hash done pulse
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      digest_q <= '0;
    end else if (digest_vld_i) begin
      digest_q <= digest_i;
    end
  end

  // Expected digest is filled one word at a time as the top of ROM streams past
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exp_q <= '0;
    end else if (exp_vld_i) begin
      exp_q[exp_idx_i] <= exp_word_i;
    end
  end

  assign digest_o     = digest_q;
  assign exp_digest_o = exp_q;

endmodule

// File: hw/rom_hash.sv
`timescale 1ns/1ps

module rom_hash #(
  parameter int TopCount = 8
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                                          busy_i,
  input  logic                                          absorb_i,
  input  logic [rom_hash_pkg::WordW-1:0]                word_i,
  input  logic                                          last_i,
  output logic                                          ready_o,
  output logic                                          done_o,
  output logic [TopCount-1:0][rom_hash_pkg::WordW-1:0]  digest_o
);

  localparam int TAW = $clog2(TopCount);
  localparam int W = rom_hash_pkg::WordW;

  typedef enum logic [1:0] {
    HashAbsorb,
    HashFinal,
    HashHold
  } hash_phase_e;

  hash_phase_e                 phase_q;
  logic [TopCount-1:0][W-1:0]  h_q;
  logic [TopCount-1:0][W-1:0]  h_d;
  logic [W-1:0]                k_q;
  logic [TAW-1:0]              j_q;
  logic [TAW-1:0]              rnd_q;
  logic                        done_q;
  logic                        take;
  logic                        round;
  logic                        last_round;
  logic [W-1:0]                mix_x;
  logic [W-1:0]                mix_rot;

  // The engine stalls whenever the outside marks it busy
  assign ready_o    = !busy_i;
  assign take       = (phase_q == HashAbsorb) && absorb_i && ready_o;
  assign round      = (phase_q == HashFinal) && ready_o;
  assign last_round = round && (rnd_q == TAW'(TopCount - 1));

  // Absorb step on chaining word j = k mod TopCount
  assign mix_x   = h_q[j_q] ^ word_i;
  assign mix_rot = (mix_x << rom_hash_pkg::RotAmt) | (mix_x >> (W - rom_hash_pkg::RotAmt));

  always_comb begin
    h_d = h_q;
    if (take) begin
      h_d[j_q] = mix_rot + k_q;
    end else if (round) begin
      // Words are updated in turn, so the last one sees the new word 0
      for (int i = 0; i < TopCount; i++) begin
        h_d[i] = h_d[i] + h_d[(i + 1) % TopCount];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= HashAbsorb;
      h_q     <= rom_hash_pkg::IvWords[TopCount-1:0];
      k_q     <= '0;
      j_q     <= '0;
      rnd_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      h_q    <= h_d;
      done_q <= last_round;
      if (take) begin
        k_q <= k_q + W'(1);
        j_q <= (j_q == TAW'(TopCount - 1)) ? '0 : j_q + TAW'(1);
        if (last_i) begin
          phase_q <= HashFinal;
        end
      end
      if (round) begin
        rnd_q <= rnd_q + TAW'(1);
      end
      // After the final round the digest is frozen
      if (last_round) begin
        phase_q <= HashHold;
      end
    end
  end

  assign done_o   = done_q;
  assign digest_o = h_q;

endmodule

// File: hw/rom_check_counter.sv
`timescale 1ns/1ps

module rom_check_counter #(
  parameter int RomDepth = 64,
  parameter int TopCount = 8
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        data_rdy_i,
  output logic [$clog2(RomDepth)-1:0] read_addr_o,
  output logic                        read_req_o,
  output logic [$clog2(RomDepth)-1:0] data_addr_o,
  output logic                        last_low_o,
  output logic                        done_o
);

  localparam int AW = $clog2(RomDepth);
  localparam logic [AW-1:0] LastLowAddr = AW'(RomDepth - TopCount - 1);
  localparam logic [AW-1:0] TopAddr = AW'(RomDepth - 1);

  // Address of the word in flight, the request and the returned data share it
  logic [AW-1:0] addr_q;
  logic          req_q;
  logic          vld_q;
  logic          done_q;
  logic          consume;
  logic          at_top;

  // A word is consumed when its data is back and the receiver takes it
  assign consume = vld_q & data_rdy_i;
  assign at_top  = (addr_q == TopAddr);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
      req_q  <= 1'b0;
      vld_q  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      // The idle case only occurs right after reset and starts the read of word 0
      // Later reads go out once the previous word has been consumed
      req_q <= (!req_q && !vld_q && !done_q) || (consume && !at_top);
      // Data arrives one cycle after the request and is held until consumed
      if (req_q) begin
        vld_q <= 1'b1;
      end else if (consume) begin
        vld_q <= 1'b0;
      end
      if (consume && !at_top) begin
        addr_q <= addr_q + AW'(1);
      end
      // Done is sticky, nothing restarts the sweep
      if (consume && at_top) begin
        done_q <= 1'b1;
      end
    end
  end

  assign read_addr_o = addr_q;
  assign read_req_o  = req_q;
  assign data_addr_o = addr_q;
  assign last_low_o  = vld_q && (addr_q == LastLowAddr);
  assign done_o      = done_q;

endmodule

// File: hw/rom_check_pkg.sv
package rom_check_pkg;

  // Number of 32-bit words handed to the key consumer
  parameter int unsigned KeyWords = 8;

  // Checker FSM states, listed in the order they are visited
  // RomAhead and HashAhead are the two branches of the race between reading and hashing
  typedef enum logic [2:0] {
    ReadingLow  = 3'd0,
    ReadingHigh = 3'd1,
    RomAhead    = 3'd2,
    HashAhead   = 3'd3,
    Checking    = 3'd4,
    Done        = 3'd5,
    Invalid     = 3'd6
  } fsm_state_e;

  // Result of the integrity check
  typedef struct packed {
    logic done;
    logic good;
  } check_status_t;

  // Computed digest as one block for the key consumer, word 0 in the low bits
  typedef struct packed {
    logic                                          valid;
    logic [KeyWords*rom_hash_pkg::WordW-1:0]       data;
  } key_data_t;

endpackage

// File: hw/rom_hash_pkg.sv
package rom_hash_pkg;

  // Width of a ROM word and of every digest word
  parameter int unsigned WordW = 32;

  // Left rotation applied after the XOR in each absorb step
  parameter int unsigned RotAmt = 5;

  // Initial chaining values, the last entry below is word 0
  parameter logic [7:0][WordW-1:0] IvWords = {
    32'h5be0cd19, 32'h1f83d9ab, 32'h9b05688c, 32'h510e527f,
    32'ha54ff53a, 32'h3c6ef372, 32'hbb67ae85, 32'h6a09e667
  };

endpackage
